/* sim.f */
verilog/mem_test_pkg.sv
verilog/wb_ctrl_regs.sv
verilog/test_sequencer.sv
verilog/read_checker.sv
verilog/app_cmd_port.sv
verilog/mem_tester_top.sv
verification/app_mem_model.sv
verification/mem_tester_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP ?= mem_tester_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(BUILD_DIR)

/* verification/mem_tester_tb.sv */
`default_nettype none

module mem_tester_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int clk_period = 10;
  localparam int line_step = 8;
  localparam int lines_run = 16 + 12 + 10 + 10;
  localparam int watchdog_cycles = lines_run * 200 + 500;

  logic clk;
  logic reset;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic [mem_test_pkg::wb_adr_width-1:0] wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic wb_ack;
  logic app_en;
  logic [2:0] app_cmd;
  logic [mem_test_pkg::addr_width-1:0] app_addr;
  logic app_rdy;
  logic app_wdf_wren;
  logic app_wdf_end;
  logic [mem_test_pkg::data_width-1:0] app_wdf_data;
  logic app_wdf_rdy;
  logic app_rd_data_valid;
  logic [mem_test_pkg::data_width-1:0] app_rd_data;

  int errors = 0;
  logic [2:0] log_cmd [$];
  logic [mem_test_pkg::addr_width-1:0] log_addr [$];

  mem_tester_top uut (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr), .app_rdy(app_rdy),
    .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data),
    .app_wdf_rdy(app_wdf_rdy), .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data)
  );

  app_mem_model mem_model (
    .clk(clk), .reset(reset),
    .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr), .app_rdy(app_rdy),
    .app_wdf_wren(app_wdf_wren), .app_wdf_data(app_wdf_data),
    .app_wdf_rdy(app_wdf_rdy), .app_rd_data_valid(app_rd_data_valid), .app_rd_data(app_rd_data)
  );

  always #(clk_period / 2) clk = ~clk;

  // every accepted command, sampled mid-cycle
  always @(negedge clk) begin
    if (!reset && app_en && app_rdy) begin
      log_cmd.push_back(app_cmd);
      log_addr.push_back(app_addr);
    end
  end

  // one beat per command, so every write data beat is also the last
  always @(negedge clk) begin
    if (!reset) begin
      if (app_wdf_wren) begin
        check_value("app_wdf_end", 32'h1, 32'(app_wdf_end));
      end else begin
        check_value("app_wdf_end", 32'h0, 32'(app_wdf_end));
      end
    end
  end

  function automatic logic [127:0] expected_line(input logic [31:0] addr,
                                                 input logic [31:0] seed);
    logic [31:0] w;
    w = addr ^ seed;
    return {w, ~w, w + 32'd1, ~(w + 32'd1)};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic wb_write(input logic [mem_test_pkg::wb_adr_width-1:0] adr,
                          input logic [31:0] data);
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b1;
    wb_adr = adr;
    wb_dat_w = data;
    @(posedge clk);
    #1;
    while (!wb_ack) begin
      @(posedge clk);
      #1;
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic wb_read(input logic [mem_test_pkg::wb_adr_width-1:0] adr,
                         output logic [31:0] data);
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = 1'b0;
    wb_adr = adr;
    @(posedge clk);
    #1;
    while (!wb_ack) begin
      @(posedge clk);
      #1;
    end
    data = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic wait_done();
    logic [31:0] status;
    status = '0;
    while (!status[1]) begin
      wb_read(mem_test_pkg::reg_status, status);
    end
  endtask

  // range, alignment, one write per line, write before read
  task automatic verify_command_log(input logic [31:0] base, input int count, input int mark);
    int writes;
    int reads;
    int idx;
    logic [31:0] offset;
    int write_count [int];
    bit read_seen [int];
    writes = 0;
    reads = 0;
    for (int i = mark; i < log_cmd.size(); i++) begin
      offset = 32'(log_addr[i]) - base;
      if (offset[2:0] != 3'd0 || offset >= count * line_step) begin
        errors++;
        $display("command %0d used address %h outside the programmed lines", i, log_addr[i]);
      end else begin
        idx = int'(offset >> 3);
        if (log_cmd[i] == mem_test_pkg::app_cmd_write) begin
          writes++;
          if (read_seen.exists(idx)) begin
            errors++;
            $display("line %0d was written after it had been read", idx);
          end
          write_count[idx] = write_count.exists(idx) ? write_count[idx] + 1 : 1;
        end else if (log_cmd[i] == mem_test_pkg::app_cmd_read) begin
          reads++;
          if (!write_count.exists(idx)) begin
            errors++;
            $display("line %0d was read before it was written", idx);
          end
          read_seen[idx] = 1'b1;
        end else begin
          errors++;
          $display("command %0d has unknown code %0d", i, log_cmd[i]);
        end
      end
    end
    check_value("write command count", count, writes);
    check_value("read command count", count, reads);
    for (int k = 0; k < count; k++) begin
      check_value($sformatf("writes to line %0d", k), 1,
                  write_count.exists(k) ? write_count[k] : 0);
    end
  endtask

  task automatic run_lines(input logic [31:0] base, input int count, input logic [31:0] seed,
                           input bit restart);
    logic [31:0] status;
    int mark;
    wb_write(mem_test_pkg::reg_base, base);
    wb_write(mem_test_pkg::reg_count, count);
    wb_write(mem_test_pkg::reg_seed, seed);
    mark = log_cmd.size();
    wb_write(mem_test_pkg::reg_ctrl, 32'h1);
    wb_read(mem_test_pkg::reg_status, status);
    check_value("status busy after start", 32'h1, status & 32'h3);
    if (restart) begin
      wb_write(mem_test_pkg::reg_ctrl, 32'h1);
    end
    wait_done();
    verify_command_log(base, count, mark);
  endtask

  task automatic check_memory(input logic [31:0] base, input int count, input logic [31:0] seed);
    logic [31:0] addr;
    logic [127:0] exp_line;
    logic [127:0] act_line;
    for (int i = 0; i < count; i++) begin
      addr = base + i * line_step;
      exp_line = expected_line(addr, seed);
      act_line = mem_model.read_line(addr[mem_test_pkg::addr_width-1:0]);
      for (int w = 0; w < 4; w++) begin
        check_value($sformatf("memory word %0d at %h", w, addr),
                    exp_line[32*w +: 32], act_line[32*w +: 32]);
      end
    end
  endtask

  task automatic check_result(input logic [31:0] status_exp, input logic [31:0] err_exp);
    logic [31:0] rdata;
    wb_read(mem_test_pkg::reg_status, rdata);
    check_value("status", status_exp, rdata);
    wb_read(mem_test_pkg::reg_err_count, rdata);
    check_value("err_count", err_exp, rdata);
  endtask

  task automatic test_register_access();
    logic [31:0] rdata;
    wb_read(mem_test_pkg::reg_status, rdata);
    check_value("status after reset", 32'h0, rdata);
    wb_write(mem_test_pkg::reg_base, 32'h0012_3440);
    wb_write(mem_test_pkg::reg_count, 32'h0000_0025);
    wb_write(mem_test_pkg::reg_seed, 32'hdead_beef);
    wb_read(mem_test_pkg::reg_base, rdata);
    check_value("base readback", 32'h0012_3440, rdata);
    wb_read(mem_test_pkg::reg_count, rdata);
    check_value("count readback", 32'h0000_0025, rdata);
    wb_read(mem_test_pkg::reg_seed, rdata);
    check_value("seed readback", 32'hdead_beef, rdata);
  endtask

  task automatic test_clean_run();
    run_lines(32'h0000_0100, 16, 32'h3c5a_0f96, 1'b0);
    check_result(32'h2, 32'h0);
    check_memory(32'h0000_0100, 16, 32'h3c5a_0f96);
  endtask

  task automatic test_injected_fault();
    logic [31:0] rdata;
    // bit 77 of line 5
    mem_model.set_fault(1'b1, 28'h000_2000 + 28'(5 * line_step), 77);
    run_lines(32'h0000_2000, 12, 32'h1357_9bdf, 1'b0);
    mem_model.set_fault(1'b0, '0, 0);
    check_result(32'h6, 32'h1);
    wb_read(mem_test_pkg::reg_fail_addr, rdata);
    check_value("fail_addr", 32'h0000_2000 + 5 * line_step, rdata);
  endtask

  task automatic test_start_while_busy();
    run_lines(32'h0004_0000, 10, 32'h0f0f_5555, 1'b1);
    check_result(32'h2, 32'h0);
    run_lines(32'h0004_0000, 10, 32'ha5a5_1234, 1'b0);
    check_result(32'h2, 32'h0);
    check_memory(32'h0004_0000, 10, 32'ha5a5_1234);
  endtask

  initial begin
    #(watchdog_cycles * clk_period);
    $display("timeout after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("sim failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    test_register_access();
    mem_model.set_stalls(1'b1);
    test_clean_run();
    test_injected_fault();
    test_start_while_busy();
    $display("checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/app_mem_model.sv */
`default_nettype none

module app_mem_model (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                app_en,
  input  logic [2:0]                          app_cmd,
  input  logic [mem_test_pkg::addr_width-1:0] app_addr,
  output logic                                app_rdy,
  input  logic                                app_wdf_wren,
  input  logic [mem_test_pkg::data_width-1:0] app_wdf_data,
  output logic                                app_wdf_rdy,
  output logic                                app_rd_data_valid,
  output logic [mem_test_pkg::data_width-1:0] app_rd_data
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] lfsr;
  logic [mem_test_pkg::data_width-1:0] mem [logic [mem_test_pkg::addr_width-1:0]];
  logic [mem_test_pkg::addr_width-1:0] wr_addr_q [$];
  logic [mem_test_pkg::data_width-1:0] wr_data_q [$];
  logic [mem_test_pkg::addr_width-1:0] rd_addr_q [$];
  int rd_due_q [$];
  int cycle;
  int last_due;
  int due;
  logic [mem_test_pkg::addr_width-1:0] wa;
  logic [mem_test_pkg::addr_width-1:0] ra;
  logic [mem_test_pkg::data_width-1:0] rd;

  logic stall_en = 1'b0;
  logic fault_en = 1'b0;
  logic [mem_test_pkg::addr_width-1:0] fault_addr = '0;
  int fault_bit = 0;

  // galois form, taps 32 22 2 1
  function automatic logic step_bit();
    logic b;
    b = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
    return b;
  endfunction

  function automatic logic [3:0] take_bits(input int n);
    logic [3:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = step_bit();
    end
    return v;
  endfunction

  task automatic set_stalls(input logic en);
    stall_en = en;
  endtask

  // flips one bit of the data returned for addr
  task automatic set_fault(input logic en, input logic [mem_test_pkg::addr_width-1:0] addr,
                           input int bitpos);
    fault_en = en;
    fault_addr = addr;
    fault_bit = bitpos;
  endtask

  function automatic logic [mem_test_pkg::data_width-1:0] read_line(
      input logic [mem_test_pkg::addr_width-1:0] addr);
    return mem.exists(addr) ? mem[addr] : '0;
  endfunction

  always @(posedge clk) begin
    if (reset) begin
      lfsr = 32'he4cf5c4f;
      cycle = 0;
      last_due = 0;
      wr_addr_q.delete();
      wr_data_q.delete();
      rd_addr_q.delete();
      rd_due_q.delete();
      app_rdy <= 1'b0;
      app_wdf_rdy <= 1'b0;
      app_rd_data_valid <= 1'b0;
      app_rd_data <= '0;
    end else begin
      cycle = cycle + 1;
      if (app_en && app_rdy) begin
        if (app_cmd == mem_test_pkg::app_cmd_read) begin
          // latency 2 to 9, never earlier than the read before it
          due = cycle + 2 + int'(take_bits(3));
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          rd_addr_q.push_back(app_addr);
          rd_due_q.push_back(due);
        end else begin
          wr_addr_q.push_back(app_addr);
        end
      end
      if (app_wdf_wren && app_wdf_rdy) begin
        wr_data_q.push_back(app_wdf_data);
      end
      while (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
        wa = wr_addr_q.pop_front();
        mem[wa] = wr_data_q.pop_front();
      end
      // reads wait for any write still missing its data
      app_rd_data_valid <= 1'b0;
      if (rd_addr_q.size() > 0 && wr_addr_q.size() == 0) begin
        if (rd_due_q[0] <= cycle) begin
          ra = rd_addr_q.pop_front();
          due = rd_due_q.pop_front();
          rd = mem.exists(ra) ? mem[ra] : '0;
          if (fault_en && ra == fault_addr) begin
            rd[fault_bit] = ~rd[fault_bit];
          end
          app_rd_data <= rd;
          app_rd_data_valid <= 1'b1;
        end
      end
      // low about a quarter of the time
      if (stall_en) begin
        app_rdy <= (take_bits(2) != 4'd0);
        app_wdf_rdy <= (take_bits(2) != 4'd0);
      end else begin
        app_rdy <= 1'b1;
        app_wdf_rdy <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/mem_tester_top.sv */
`default_nettype none

module mem_tester_top (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     wb_cyc,
  input  logic                                     wb_stb,
  input  logic                                     wb_we,
  input  logic [mem_test_pkg::wb_adr_width-1:0]    wb_adr,
  input  logic [mem_test_pkg::wb_data_width-1:0]   wb_dat_w,
  output logic [mem_test_pkg::wb_data_width-1:0]   wb_dat_r,
  output logic                                     wb_ack,
  output logic                                     app_en,
  output logic [2:0]                               app_cmd,
  output logic [mem_test_pkg::addr_width-1:0]      app_addr,
  input  logic                                     app_rdy,
  output logic                                     app_wdf_wren,
  output logic                                     app_wdf_end,
  output logic [mem_test_pkg::data_width-1:0]      app_wdf_data,
  input  logic                                     app_wdf_rdy,
  input  logic                                     app_rd_data_valid,
  input  logic [mem_test_pkg::data_width-1:0]      app_rd_data
);

  // configuration and status
  logic start;
  logic busy;
  logic done;
  logic clear;
  logic [mem_test_pkg::addr_width-1:0] base_addr;
  logic [mem_test_pkg::wb_data_width-1:0] line_count;
  logic [mem_test_pkg::wb_data_width-1:0] seed;
  logic [mem_test_pkg::wb_data_width-1:0] err_count;
  logic [mem_test_pkg::addr_width-1:0] fail_addr;

  // sequencer to port handshakes
  logic cmd_valid;
  logic cmd_ready;
  mem_test_pkg::app_cmd_e cmd_code;
  logic [mem_test_pkg::addr_width-1:0] cmd_addr;
  logic wd_valid;
  logic wd_ready;
  logic [mem_test_pkg::data_width-1:0] wd_data;

  wb_ctrl_regs u_regs (
    .clk(clk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .busy(busy), .done(done), .err_count(err_count), .fail_addr(fail_addr),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .start(start),
    .base_addr(base_addr), .line_count(line_count), .seed(seed)
  );

  test_sequencer u_seq (
    .clk(clk), .reset(reset), .start(start),
    .base_addr(base_addr), .line_count(line_count), .seed(seed),
    .cmd_ready(cmd_ready), .wd_ready(wd_ready), .rd_data_valid(app_rd_data_valid),
    .cmd_valid(cmd_valid), .cmd_code(cmd_code), .cmd_addr(cmd_addr),
    .wd_valid(wd_valid), .wd_data(wd_data), .busy(busy), .done(done), .clear(clear)
  );

  read_checker u_check (
    .clk(clk), .reset(reset), .clear(clear), .base_addr(base_addr), .seed(seed),
    .rd_data_valid(app_rd_data_valid), .rd_data(app_rd_data),
    .err_count(err_count), .fail_addr(fail_addr)
  );

  app_cmd_port u_port (
    .clk(clk), .reset(reset),
    .cmd_valid(cmd_valid), .cmd_code(cmd_code), .cmd_addr(cmd_addr),
    .wd_valid(wd_valid), .wd_data(wd_data), .app_rdy(app_rdy), .app_wdf_rdy(app_wdf_rdy),
    .cmd_ready(cmd_ready), .wd_ready(wd_ready),
    .app_en(app_en), .app_cmd(app_cmd), .app_addr(app_addr),
    .app_wdf_wren(app_wdf_wren), .app_wdf_end(app_wdf_end), .app_wdf_data(app_wdf_data)
  );

endmodule

`default_nettype wire

/* verilog/app_cmd_port.sv */
`default_nettype none

module app_cmd_port (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     cmd_valid,
  input  mem_test_pkg::app_cmd_e                   cmd_code,
  input  logic [mem_test_pkg::addr_width-1:0]      cmd_addr,
  input  logic                                     wd_valid,
  input  logic [mem_test_pkg::data_width-1:0]      wd_data,
  input  logic                                     app_rdy,
  input  logic                                     app_wdf_rdy,
  output logic                                     cmd_ready,
  output logic                                     wd_ready,
  output logic                                     app_en,
  output logic [2:0]                               app_cmd,
  output logic [mem_test_pkg::addr_width-1:0]      app_addr,
  output logic                                     app_wdf_wren,
  output logic                                     app_wdf_end,
  output logic [mem_test_pkg::data_width-1:0]      app_wdf_data
);

  // register free now, or freed by the controller this cycle
  assign cmd_ready = !app_en || app_rdy;
  assign wd_ready = !app_wdf_wren || app_wdf_rdy;

  // single beat per command
  assign app_wdf_end = app_wdf_wren;

  // command channel
  always_ff @(posedge clk) begin
    if (reset) begin
      app_en <= 1'b0;
    end else if (cmd_valid && cmd_ready) begin
      app_en <= 1'b1;
    end else if (app_rdy) begin
      app_en <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      app_cmd <= cmd_code;
      app_addr <= cmd_addr;
    end
  end

  // write data channel
  always_ff @(posedge clk) begin
    if (reset) begin
      app_wdf_wren <= 1'b0;
    end else if (wd_valid && wd_ready) begin
      app_wdf_wren <= 1'b1;
    end else if (app_wdf_rdy) begin
      app_wdf_wren <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wd_valid && wd_ready) begin
      app_wdf_data <= wd_data;
    end
  end

  cmd_held_on_stall: assert property (
    @(posedge clk) disable iff (reset)
    (app_en && !app_rdy) |=> (app_en && $stable(app_cmd) && $stable(app_addr))
  );

  wdf_held_on_stall: assert property (
    @(posedge clk) disable iff (reset)
    (app_wdf_wren && !app_wdf_rdy) |=> (app_wdf_wren && $stable(app_wdf_data))
  );

endmodule

`default_nettype wire

/* verilog/read_checker.sv */
`default_nettype none

module read_checker (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     clear,
  input  logic [mem_test_pkg::addr_width-1:0]      base_addr,
  input  logic [mem_test_pkg::wb_data_width-1:0]   seed,
  input  logic                                     rd_data_valid,
  input  logic [mem_test_pkg::data_width-1:0]      rd_data,
  output logic [mem_test_pkg::wb_data_width-1:0]   err_count,
  output logic [mem_test_pkg::addr_width-1:0]      fail_addr
);

  logic [mem_test_pkg::addr_width-1:0] exp_addr;
  logic [mem_test_pkg::data_width-1:0] exp_data;
  logic mismatch;

  // reads return in issue order, so a local counter tracks the address
  assign exp_data = mem_test_pkg::pattern(exp_addr, seed);
  assign mismatch = rd_data_valid && (rd_data != exp_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      exp_addr <= '0;
    end else if (clear) begin
      exp_addr <= base_addr;
    end else if (rd_data_valid) begin
      exp_addr <= exp_addr + mem_test_pkg::addr_step;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      err_count <= '0;
      fail_addr <= '0;
    end else if (mismatch) begin
      // zero count means this is the first failure of the run
      if (err_count == '0) begin
        fail_addr <= exp_addr;
      end
      // saturate
      if (err_count != '1) begin
        err_count <= err_count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/test_sequencer.sv */
`default_nettype none

module test_sequencer (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     start,
  input  logic [mem_test_pkg::addr_width-1:0]      base_addr,
  input  logic [mem_test_pkg::wb_data_width-1:0]   line_count,
  input  logic [mem_test_pkg::wb_data_width-1:0]   seed,
  input  logic                                     cmd_ready,
  input  logic                                     wd_ready,
  input  logic                                     rd_data_valid,
  output logic                                     cmd_valid,
  output mem_test_pkg::app_cmd_e                   cmd_code,
  output logic [mem_test_pkg::addr_width-1:0]      cmd_addr,
  output logic                                     wd_valid,
  output logic [mem_test_pkg::data_width-1:0]      wd_data,
  output logic                                     busy,
  output logic                                     done,
  output logic                                     clear
);

  mem_test_pkg::seq_state_e state;
  logic [mem_test_pkg::addr_width-1:0] addr;
  logic [mem_test_pkg::wb_data_width-1:0] remaining;
  logic [mem_test_pkg::out_width-1:0] outstanding;
  logic cmd_sent;
  logic wd_sent;
  logic cmd_fire;
  logic wd_fire;
  logic rd_fire;
  logic line_written;
  logic last_line;

  assign busy = state inside {mem_test_pkg::seq_write, mem_test_pkg::seq_read,
                              mem_test_pkg::seq_drain};
  assign done = (state == mem_test_pkg::seq_done);
  // checker restarts with the run
  assign clear = start && !busy;

  assign last_line = (remaining == 1);

  // valids come from registered state only
  assign cmd_valid = ((state == mem_test_pkg::seq_write) && !cmd_sent) ||
                     ((state == mem_test_pkg::seq_read) &&
                      (outstanding < mem_test_pkg::max_outstanding));
  assign wd_valid = (state == mem_test_pkg::seq_write) && !wd_sent;
  assign cmd_code = (state == mem_test_pkg::seq_read) ? mem_test_pkg::app_cmd_read
                                                      : mem_test_pkg::app_cmd_write;
  assign cmd_addr = addr;
  assign wd_data = mem_test_pkg::pattern(addr, seed);

  assign cmd_fire = cmd_valid && cmd_ready;
  assign wd_fire = wd_valid && wd_ready;
  assign rd_fire = cmd_fire && (state == mem_test_pkg::seq_read);
  // command and data of a line may go in different cycles
  assign line_written = (cmd_sent || cmd_fire) && (wd_sent || wd_fire);

  always_ff @(posedge clk) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      case ({rd_fire, rd_data_valid})
        2'b10: outstanding <= outstanding + 1'b1;
        2'b01: outstanding <= outstanding - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mem_test_pkg::seq_idle;
      addr <= '0;
      remaining <= '0;
      cmd_sent <= 1'b0;
      wd_sent <= 1'b0;
    end else begin
      case (state)
        mem_test_pkg::seq_idle, mem_test_pkg::seq_done: begin
          if (start) begin
            addr <= base_addr;
            remaining <= line_count;
            cmd_sent <= 1'b0;
            wd_sent <= 1'b0;
            // empty run goes straight to completion
            state <= (line_count == '0) ? mem_test_pkg::seq_drain : mem_test_pkg::seq_write;
          end
        end
        mem_test_pkg::seq_write: begin
          if (line_written) begin
            cmd_sent <= 1'b0;
            wd_sent <= 1'b0;
            if (last_line) begin
              addr <= base_addr;
              remaining <= line_count;
              state <= mem_test_pkg::seq_read;
            end else begin
              addr <= addr + mem_test_pkg::addr_step;
              remaining <= remaining - 1'b1;
            end
          end else begin
            if (cmd_fire) cmd_sent <= 1'b1;
            if (wd_fire) wd_sent <= 1'b1;
          end
        end
        mem_test_pkg::seq_read: begin
          if (cmd_fire) begin
            addr <= addr + mem_test_pkg::addr_step;
            remaining <= remaining - 1'b1;
            if (last_line) state <= mem_test_pkg::seq_drain;
          end
        end
        mem_test_pkg::seq_drain: begin
          if (outstanding == '0) state <= mem_test_pkg::seq_done;
        end
        default: state <= mem_test_pkg::seq_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/wb_ctrl_regs.sv */
`default_nettype none

module wb_ctrl_regs (
  input  logic                                     clk,
  input  logic                                     reset,
  input  logic                                     wb_cyc,
  input  logic                                     wb_stb,
  input  logic                                     wb_we,
  input  logic [mem_test_pkg::wb_adr_width-1:0]    wb_adr,
  input  logic [mem_test_pkg::wb_data_width-1:0]   wb_dat_w,
  input  logic                                     busy,
  input  logic                                     done,
  input  logic [mem_test_pkg::wb_data_width-1:0]   err_count,
  input  logic [mem_test_pkg::addr_width-1:0]      fail_addr,
  output logic [mem_test_pkg::wb_data_width-1:0]   wb_dat_r,
  output logic                                     wb_ack,
  output logic                                     start,
  output logic [mem_test_pkg::addr_width-1:0]      base_addr,
  output logic [mem_test_pkg::wb_data_width-1:0]   line_count,
  output logic [mem_test_pkg::wb_data_width-1:0]   seed
);

  localparam int pad_width = mem_test_pkg::wb_data_width - mem_test_pkg::addr_width;

  logic req;
  logic [mem_test_pkg::wb_data_width-1:0] status;

  // new request only in the first cycle, ack drops the strobe decode
  assign req = wb_cyc && wb_stb && !wb_ack;

  assign status = {{(mem_test_pkg::wb_data_width - 3){1'b0}}, (err_count != '0), done, busy};

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      start <= 1'b0;
      base_addr <= '0;
      line_count <= '0;
      seed <= '0;
    end else begin
      wb_ack <= req;
      // start ignored while a run is active
      start <= req && wb_we && (wb_adr == mem_test_pkg::reg_ctrl) && wb_dat_w[0] && !busy;
      if (req && wb_we) begin
        case (wb_adr)
          mem_test_pkg::reg_base: base_addr <= wb_dat_w[mem_test_pkg::addr_width-1:0];
          mem_test_pkg::reg_count: line_count <= wb_dat_w;
          mem_test_pkg::reg_seed: seed <= wb_dat_w;
          default: ;
        endcase
      end
    end
  end

  // read data lines up with ack
  always_ff @(posedge clk) begin
    if (req) begin
      case (wb_adr)
        mem_test_pkg::reg_ctrl: wb_dat_r <= {{(mem_test_pkg::wb_data_width - 1){1'b0}}, busy};
        mem_test_pkg::reg_base: wb_dat_r <= {{pad_width{1'b0}}, base_addr};
        mem_test_pkg::reg_count: wb_dat_r <= line_count;
        mem_test_pkg::reg_seed: wb_dat_r <= seed;
        mem_test_pkg::reg_status: wb_dat_r <= status;
        mem_test_pkg::reg_err_count: wb_dat_r <= err_count;
        mem_test_pkg::reg_fail_addr: wb_dat_r <= {{pad_width{1'b0}}, fail_addr};
        default: wb_dat_r <= '0;
      endcase
    end
  end

  ack_single_cycle: assert property (
    @(posedge clk) disable iff (reset) wb_ack |=> !wb_ack
  );

endmodule

`default_nettype wire

/* verilog/mem_test_pkg.sv */
`default_nettype none

package mem_test_pkg;

  // app interface widths
  localparam int addr_width = 28;
  localparam int data_width = 128;

  // one line per command, column units
  localparam logic [addr_width-1:0] addr_step = addr_width'(8);

  // wishbone port
  localparam int wb_adr_width = 3;
  localparam int wb_data_width = 32;

  // register word indices
  localparam logic [wb_adr_width-1:0] reg_ctrl = 3'd0;
  localparam logic [wb_adr_width-1:0] reg_base = 3'd1;
  localparam logic [wb_adr_width-1:0] reg_count = 3'd2;
  localparam logic [wb_adr_width-1:0] reg_seed = 3'd3;
  localparam logic [wb_adr_width-1:0] reg_status = 3'd4;
  localparam logic [wb_adr_width-1:0] reg_err_count = 3'd5;
  localparam logic [wb_adr_width-1:0] reg_fail_addr = 3'd6;

  // reads in flight, counter wide enough to hold the limit itself
  localparam int out_width = 3;
  localparam logic [out_width-1:0] max_outstanding = 3'd4;

  typedef enum logic [2:0] {
    app_cmd_write = 3'd0,
    app_cmd_read  = 3'd1
  } app_cmd_e;

  typedef enum logic [2:0] {
    seq_idle,
    seq_write,
    seq_read,
    seq_drain,
    seq_done
  } seq_state_e;

  // word3 = addr ^ seed, then ~word3, word3 + 1, ~(word3 + 1)
  function automatic logic [data_width-1:0] pattern(input logic [addr_width-1:0] addr,
                                                   input logic [31:0] seed);
    logic [31:0] word;
    logic [31:0] word_inc;
    word = {{(32 - addr_width){1'b0}}, addr} ^ seed;
    word_inc = word + 32'd1;
    return {word, ~word, word_inc, ~word_inc};
  endfunction

endpackage

`default_nettype wire
